/* frontend_vectors.txt */
# M addr word, U pc taken target, F flush target
# E pc word taken target, expected deliveries in order
M 00000000 00100093
M 00000004 00200113
M 00000008 00300193
M 0000000c 0340006f
M 00000040 02000063
M 00000060 00009863
M 00000064 00400213
M 00000068 00008067
M 00000080 00500293
M 00000084 00600313
M 00000100 00800413
M 00000104 00010067
M 00000108 fe000ce3
U 00000040 1 00000060
U 00000068 1 00000080
U 00000108 1 00000100
E 00000000 00100093 0 00000004
E 00000004 00200113 0 00000008
E 00000008 00300193 0 0000000c
E 0000000c 0340006f 1 00000040
E 00000040 02000063 1 00000060
E 00000060 00009863 0 00000064
E 00000064 00400213 0 00000068
E 00000068 00008067 1 00000080
E 00000080 00500293 0 00000084
E 00000084 00600313 0 00000088
F 00000100
E 00000100 00800413 0 00000104
E 00000104 00010067 0 00000108
E 00000108 fe000ce3 1 00000100
E 00000100 00800413 0 00000104
E 00000104 00010067 0 00000108
E 00000108 fe000ce3 1 00000100
F 00000200
E 00000200 00000013 0 00000204

/* build.f */
frontend_pkg.sv
pc_reg.sv
branch_predictor.sv
predecoder.sv
inst_buffer.sv
frontend_top.sv
tb_clock_gen.sv
tb_frontend.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - files:
      - frontend_pkg.sv
      - pc_reg.sv
      - branch_predictor.sv
      - predecoder.sv
      - inst_buffer.sv
      - frontend_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_frontend.sv

/* tb_frontend.sv */
`default_nettype none

module tb_frontend;

    logic        clk;
    logic        rst;
    logic [31:0] fetch_pc;
    logic        fetch_en;
    logic [31:0] fetch_inst;
    logic        inst_req;
    logic        inst_ack;
    logic [31:0] inst_pc;
    logic [31:0] inst_word;
    logic        pred_taken;
    logic [31:0] pred_target;
    logic        branch_flush;
    logic [31:0] flush_target;
    logic        upd_valid;
    logic [31:0] upd_pc;
    logic        upd_taken;
    logic [31:0] upd_target;

    // Instruction memory model of 1 KB
    logic [31:0] imem [256];

    // Training, flushes and expected deliveries from the vector file
    logic [31:0] upd_pc_q     [$];
    logic        upd_taken_q  [$];
    logic [31:0] upd_target_q [$];
    logic [7:0]  step_kind    [$];
    logic [31:0] step_pc      [$];
    logic [31:0] step_word    [$];
    logic        step_taken   [$];
    logic [31:0] step_target  [$];

    int error_count = 0;
    int delivered   = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    // Queue occupancy rebuilt from fetches and handshakes
    int   queue_fill = 0;
    logic fetch_expected;

    tb_clock_gen u_clock_gen (
        .clk
    );

    frontend_top u_frontend_top (
        .clk, .rst,
        .fetch_pc, .fetch_en, .fetch_inst,
        .inst_req, .inst_ack, .inst_pc, .inst_word,
        .pred_taken, .pred_target,
        .branch_flush, .flush_target,
        .upd_valid, .upd_pc, .upd_taken, .upd_target
    );

    // Words come back in the same cycle with a nop outside the model
    assign fetch_inst = (fetch_pc[31:10] == '0) ? imem[fetch_pc[9:2]] : 32'h0000_0013;

    ////////////////////////////////////////
    // Vector file
    ////////////////////////////////////////

    task automatic read_vectors();
        int               fd;
        int               rc;
        logic [7:0]       tag;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [31:0]      d;
        logic [8*160-1:0] rest;
        fd = $fopen("frontend_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open frontend_vectors.txt");
            error_count++;
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                case (tag)
                    "#": rc = $fgets(rest, fd);
                    "M": begin
                        rc = $fscanf(fd, " %h %h", a, b);
                        imem[a[9:2]] = b;
                    end
                    "U": begin
                        rc = $fscanf(fd, " %h %h %h", a, b, c);
                        upd_pc_q.push_back(a);
                        upd_taken_q.push_back(b[0]);
                        upd_target_q.push_back(c);
                    end
                    "F", "E": begin
                        if (tag == "F") begin
                            rc = $fscanf(fd, " %h", a);
                            b = '0;
                            c = '0;
                            d = '0;
                        end else begin
                            rc = $fscanf(fd, " %h %h %h %h", a, b, c, d);
                        end
                        step_kind.push_back(tag);
                        step_pc.push_back(a);
                        step_word.push_back(b);
                        step_taken.push_back(c[0]);
                        step_target.push_back(d);
                    end
                    default: begin
                        $display("Unknown tag in the vector file: %c", tag);
                        error_count++;
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////
    // Backend model
    ////////////////////////////////////////

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // One four-phase transfer checked when ack rises
    task automatic deliver_one(input int idx);
        int delay;
        @(posedge clk);
        while (!inst_req) begin
            @(posedge clk);
        end
        delay = $urandom % 4;
        repeat (delay) @(posedge clk);
        inst_ack <= 1'b1;
        compare_field("inst_pc", step_pc[idx], inst_pc);
        compare_field("inst_word", step_word[idx], inst_word);
        compare_field("pred_taken", {31'd0, step_taken[idx]}, {31'd0, pred_taken});
        compare_field("pred_target", step_target[idx], pred_target);
        @(posedge clk);
        while (inst_req) begin
            @(posedge clk);
        end
        delay = $urandom % 4;
        repeat (delay) @(posedge clk);
        inst_ack <= 1'b0;
        delivered++;
    endtask

    task automatic issue_flush(input logic [31:0] target);
        @(posedge clk);
        branch_flush <= 1'b1;
        flush_target <= target;
        @(posedge clk);
        branch_flush <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Fetch enable
    ////////////////////////////////////////

    // No fetch in reset, in a flush cycle or with four entries queued
    always @(posedge clk) begin
        fetch_expected = !rst && !branch_flush && (queue_fill < 4);
        compare_field("fetch_en", {31'd0, fetch_expected}, {31'd0, fetch_en});
        if (rst || branch_flush) begin
            queue_fill = 0;
        end else begin
            queue_fill = queue_fill + fetch_expected - (inst_req && inst_ack);
        end
    end

    initial begin
        int seed;
        int expect_total;
        seed = $urandom(32'h0a3d0ffd);
        rst          = 1'b1;
        inst_ack     = 1'b0;
        branch_flush = 1'b0;
        flush_target = '0;
        upd_valid    = 1'b0;
        upd_pc       = '0;
        upd_taken    = 1'b0;
        upd_target   = '0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013;
        end
        read_vectors();
        expect_total = 0;
        foreach (step_kind[i]) begin
            if (step_kind[i] == "E") begin
                expect_total++;
            end
        end
        cycle_limit = 40 * expect_total + 100;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // Flush held at the reset pc keeps fetch off while the BTB trains
        branch_flush <= 1'b1;
        flush_target <= 32'h0000_0000;
        foreach (upd_pc_q[i]) begin
            upd_valid  <= 1'b1;
            upd_pc     <= upd_pc_q[i];
            upd_taken  <= upd_taken_q[i];
            upd_target <= upd_target_q[i];
            @(posedge clk);
        end
        upd_valid    <= 1'b0;
        branch_flush <= 1'b0;

        foreach (step_kind[i]) begin
            if (step_kind[i] == "F") begin
                issue_flush(step_pc[i]);
            end else begin
                deliver_one(i);
            end
        end

        $display("Run complete: %0d deliveries checked, %0d errors", delivered, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped delivering", cycle_count);
            $display("Run stopped: %0d deliveries checked, %0d errors", delivered, error_count);
            $display("Errors found");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // Free-running clock, 40-unit period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* frontend_top.sv */
`default_nettype none

module frontend_top (
    input  wire logic                         clk,
    input  wire logic                         rst,

    // Instruction memory
    output logic      [frontend_pkg::xlen-1:0] fetch_pc,
    output logic                              fetch_en,
    input  wire logic [frontend_pkg::xlen-1:0] fetch_inst,

    // Delivery to the backend
    output logic                              inst_req,
    input  wire logic                         inst_ack,
    output logic      [frontend_pkg::xlen-1:0] inst_pc,
    output logic      [frontend_pkg::xlen-1:0] inst_word,
    output logic                              pred_taken,
    output logic      [frontend_pkg::xlen-1:0] pred_target,

    // Backend flush and BTB training
    input  wire logic                         branch_flush,
    input  wire logic [frontend_pkg::xlen-1:0] flush_target,
    input  wire logic                         upd_valid,
    input  wire logic [frontend_pkg::xlen-1:0] upd_pc,
    input  wire logic                         upd_taken,
    input  wire logic [frontend_pkg::xlen-1:0] upd_target
);

    // pc_reg feedback
    logic                          redirect;
    logic [frontend_pkg::xlen-1:0] redirect_target;
    logic                          ibuf_full;

    // Predictor and predecoder results
    logic                          btb_hit;
    logic                          btb_taken;
    logic [frontend_pkg::xlen-1:0] btb_target;
    frontend_pkg::br_kind_e        br_kind;
    logic [frontend_pkg::xlen-1:0] direct_target;

    pc_reg u_pc_reg (
        .clk, .rst,
        .branch_flush, .flush_target,
        .redirect, .redirect_target, .ibuf_full,
        .fetch_pc, .fetch_en
    );

    branch_predictor u_branch_predictor (
        .clk, .rst,
        .fetch_pc,
        .upd_valid, .upd_pc, .upd_taken, .upd_target,
        .btb_hit, .btb_taken, .btb_target
    );

    predecoder u_predecoder (
        .fetch_pc, .fetch_inst,
        .br_kind, .direct_target
    );

    inst_buffer u_inst_buffer (
        .clk, .rst, .branch_flush,
        .fetch_en, .fetch_pc, .fetch_inst,
        .br_kind, .direct_target,
        .btb_hit, .btb_taken, .btb_target,
        .redirect, .redirect_target, .ibuf_full,
        .inst_req, .inst_ack, .inst_pc, .inst_word,
        .pred_taken, .pred_target
    );

endmodule

`default_nettype wire

/* inst_buffer.sv */
`default_nettype none

module inst_buffer (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         branch_flush,

    // Current fetch and the two lookups
    input  wire logic                         fetch_en,
    input  wire logic [frontend_pkg::xlen-1:0] fetch_pc,
    input  wire logic [frontend_pkg::xlen-1:0] fetch_inst,
    input  wire frontend_pkg::br_kind_e       br_kind,
    input  wire logic [frontend_pkg::xlen-1:0] direct_target,
    input  wire logic                         btb_hit,
    input  wire logic                         btb_taken,
    input  wire logic [frontend_pkg::xlen-1:0] btb_target,

    // Back to pc_reg
    output logic                              redirect,
    output logic      [frontend_pkg::xlen-1:0] redirect_target,
    output logic                              ibuf_full,

    // Backend handshake
    output logic                              inst_req,
    input  wire logic                         inst_ack,
    output logic      [frontend_pkg::xlen-1:0] inst_pc,
    output logic      [frontend_pkg::xlen-1:0] inst_word,
    output logic                              pred_taken,
    output logic      [frontend_pkg::xlen-1:0] pred_target
);

    logic [frontend_pkg::xlen-1:0] pc_mem     [frontend_pkg::ibuf_depth];
    logic [frontend_pkg::xlen-1:0] word_mem   [frontend_pkg::ibuf_depth];
    logic                          taken_mem  [frontend_pkg::ibuf_depth];
    logic [frontend_pkg::xlen-1:0] target_mem [frontend_pkg::ibuf_depth];

    logic [frontend_pkg::ibuf_ptr_bits-1:0] wr_ptr;
    logic [frontend_pkg::ibuf_ptr_bits-1:0] rd_ptr;
    logic [frontend_pkg::ibuf_ptr_bits:0]   count;

    logic                          taken_c;
    logic [frontend_pkg::xlen-1:0] target_c;
    logic                          push;
    logic                          pop;
    frontend_pkg::hs_state_e       state;

    ////////////////////////////////////////
    // Final prediction
    ////////////////////////////////////////

    always_comb begin
        taken_c  = 1'b0;
        target_c = fetch_pc + 32'd4;
        case (br_kind)
            frontend_pkg::br_jal: begin
                taken_c  = 1'b1;
                target_c = direct_target;
            end
            frontend_pkg::br_cond: begin
                if (btb_hit && btb_taken) begin
                    taken_c  = 1'b1;
                    target_c = direct_target;
                end
            end
            // Indirect jump needs a BTB entry to go anywhere
            frontend_pkg::br_jalr: begin
                if (btb_hit) begin
                    taken_c  = 1'b1;
                    target_c = btb_target;
                end
            end
            default: ;
        endcase
    end

    assign redirect        = fetch_en && taken_c;
    assign redirect_target = target_c;

    ////////////////////////////////////////
    // Fetch queue
    ////////////////////////////////////////

    assign push      = fetch_en && !branch_flush;
    assign pop       = (state == frontend_pkg::hs_req) && inst_ack && !branch_flush;
    assign ibuf_full = (count == frontend_pkg::ibuf_depth);

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]     <= fetch_pc;
            word_mem[wr_ptr]   <= fetch_inst;
            taken_mem[wr_ptr]  <= taken_c;
            target_mem[wr_ptr] <= target_c;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || branch_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + push - pop;
        end
    end

    ////////////////////////////////////////
    // Four-phase req/ack
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || branch_flush) begin
            state <= frontend_pkg::hs_idle;
        end else begin
            case (state)
                frontend_pkg::hs_idle: begin
                    if (count != 0 && !inst_ack) state <= frontend_pkg::hs_req;
                end
                frontend_pkg::hs_req: begin
                    if (inst_ack) state <= frontend_pkg::hs_wait_release;
                end
                frontend_pkg::hs_wait_release: begin
                    // count already reflects the pop
                    if (!inst_ack) begin
                        state <= (count != 0) ? frontend_pkg::hs_req : frontend_pkg::hs_idle;
                    end
                end
                default: state <= frontend_pkg::hs_idle;
            endcase
        end
    end

    // Head entry stays put until the pop
    assign inst_req    = (state == frontend_pkg::hs_req);
    assign inst_pc     = pc_mem[rd_ptr];
    assign inst_word   = word_mem[rd_ptr];
    assign pred_taken  = taken_mem[rd_ptr];
    assign pred_target = target_mem[rd_ptr];

endmodule

`default_nettype wire

/* predecoder.sv */
`default_nettype none

module predecoder (
    input  wire logic [frontend_pkg::xlen-1:0] fetch_pc,
    input  wire logic [frontend_pkg::xlen-1:0] fetch_inst,
    output frontend_pkg::br_kind_e            br_kind,
    output logic      [frontend_pkg::xlen-1:0] direct_target
);

    frontend_pkg::opcode_e         opcode;
    logic [2:0]                    funct3;
    logic [frontend_pkg::xlen-1:0] imm_j;
    logic [frontend_pkg::xlen-1:0] imm_b;

    assign funct3 = fetch_inst[14:12];

    ////////////////////////////////////////
    // Opcode and class
    ////////////////////////////////////////

    always_comb begin
        case (fetch_inst[6:0])
            frontend_pkg::op_jal:    opcode = frontend_pkg::op_jal;
            frontend_pkg::op_jalr:   opcode = frontend_pkg::op_jalr;
            frontend_pkg::op_branch: opcode = frontend_pkg::op_branch;
            default:                 opcode = frontend_pkg::op_other;
        endcase
    end

    always_comb begin
        case (opcode)
            frontend_pkg::op_jal:  br_kind = frontend_pkg::br_jal;
            frontend_pkg::op_jalr: br_kind = frontend_pkg::br_jalr;
            frontend_pkg::op_branch: begin
                // funct3 010 and 011 are not defined for branches
                if (funct3[2:1] == 2'b01) begin
                    br_kind = frontend_pkg::br_none;
                end else begin
                    br_kind = frontend_pkg::br_cond;
                end
            end
            default: br_kind = frontend_pkg::br_none;
        endcase
    end

    ////////////////////////////////////////
    // Immediates and direct target
    ////////////////////////////////////////

    // J-type: imm[20|10:1|11|19:12]
    assign imm_j = {{12{fetch_inst[31]}}, fetch_inst[19:12], fetch_inst[20],
                    fetch_inst[30:21], 1'b0};

    // B-type: imm[12|10:5] ... imm[4:1|11]
    assign imm_b = {{20{fetch_inst[31]}}, fetch_inst[7], fetch_inst[30:25],
                    fetch_inst[11:8], 1'b0};

    // Only meaningful for jal and conditional branches
    assign direct_target = fetch_pc + ((opcode == frontend_pkg::op_jal) ? imm_j : imm_b);

endmodule

`default_nettype wire

/* branch_predictor.sv */
`default_nettype none

module branch_predictor (
    input  wire logic                         clk,
    input  wire logic                         rst,

    // Lookup side
    input  wire logic [frontend_pkg::xlen-1:0] fetch_pc,

    // Training from the backend
    input  wire logic                         upd_valid,
    input  wire logic [frontend_pkg::xlen-1:0] upd_pc,
    input  wire logic                         upd_taken,
    input  wire logic [frontend_pkg::xlen-1:0] upd_target,

    // Lookup result
    output logic                              btb_hit,
    output logic                              btb_taken,
    output logic      [frontend_pkg::xlen-1:0] btb_target
);

    localparam int idx_hi = frontend_pkg::btb_index_bits + 1;
    localparam int tag_lo = frontend_pkg::xlen - frontend_pkg::btb_tag_bits;

    logic                              valid_q  [frontend_pkg::btb_entries];
    logic [1:0]                        cnt_q    [frontend_pkg::btb_entries];
    logic [frontend_pkg::btb_tag_bits-1:0] tag_q [frontend_pkg::btb_entries];
    logic [frontend_pkg::xlen-1:0]     target_q [frontend_pkg::btb_entries];

    logic [frontend_pkg::btb_index_bits-1:0] rd_idx;
    logic [frontend_pkg::btb_tag_bits-1:0]   rd_tag;
    logic [frontend_pkg::btb_index_bits-1:0] upd_idx;
    logic [frontend_pkg::btb_tag_bits-1:0]   upd_tag;
    logic                                    upd_hit;

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////

    assign rd_idx = fetch_pc[idx_hi:2];
    assign rd_tag = fetch_pc[frontend_pkg::xlen-1:tag_lo];

    assign btb_hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    // Weakly or strongly taken
    assign btb_taken  = btb_hit && cnt_q[rd_idx][1];
    assign btb_target = target_q[rd_idx];

    ////////////////////////////////////////
    // Training
    ////////////////////////////////////////

    assign upd_idx = upd_pc[idx_hi:2];
    assign upd_tag = upd_pc[frontend_pkg::xlen-1:tag_lo];
    assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < frontend_pkg::btb_entries; i++) begin
                valid_q[i] <= 1'b0;
                cnt_q[i]   <= 2'b00;
            end
        end else if (upd_valid) begin
            if (upd_hit) begin
                // Saturating 2-bit counter
                if (upd_taken && cnt_q[upd_idx] != 2'b11) begin
                    cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'd1;
                end else if (!upd_taken && cnt_q[upd_idx] != 2'b00) begin
                    cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'd1;
                end
            end else if (upd_taken) begin
                // Install as weakly taken, misses that were not taken are dropped
                valid_q[upd_idx] <= 1'b1;
                cnt_q[upd_idx]   <= 2'b10;
            end
        end
    end

    // Tag and target follow every taken update
    always_ff @(posedge clk) begin
        if (upd_valid && upd_taken) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= upd_target;
        end
    end

endmodule

`default_nettype wire

/* pc_reg.sv */
`default_nettype none

module pc_reg (
    input  wire logic                         clk,
    input  wire logic                         rst,

    // Backend correction
    input  wire logic                         branch_flush,
    input  wire logic [frontend_pkg::xlen-1:0] flush_target,

    // Predicted redirect from the instruction buffer
    input  wire logic                         redirect,
    input  wire logic [frontend_pkg::xlen-1:0] redirect_target,
    input  wire logic                         ibuf_full,

    // Instruction memory port
    output logic      [frontend_pkg::xlen-1:0] fetch_pc,
    output logic                              fetch_en
);

    logic [frontend_pkg::xlen-1:0] pc_q;
    logic [frontend_pkg::xlen-1:0] pc_next;

    ////////////////////////////////////////
    // Next pc selection
    ////////////////////////////////////////

    // Flush beats stall, stall beats the prediction
    always_comb begin
        if (branch_flush) begin
            pc_next = flush_target;
        end else if (ibuf_full) begin
            pc_next = pc_q;
        end else if (redirect) begin
            pc_next = redirect_target;
        end else begin
            pc_next = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= frontend_pkg::reset_pc;
        end else begin
            pc_q <= pc_next;
        end
    end

    // No fetch in reset, in a flush cycle or with the queue full
    assign fetch_en = !rst && !branch_flush && !ibuf_full;
    assign fetch_pc = pc_q;

endmodule

`default_nettype wire

/* frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

    ////////////////////////////////////////
    // Widths and depths
    ////////////////////////////////////////

    // Instruction and address width
    localparam int xlen = 32;

    // Direct-mapped BTB, indexed by pc[5:2], tagged by pc[31:6]
    localparam int btb_entries    = 16;
    localparam int btb_index_bits = 4;
    localparam int btb_tag_bits   = 26;

    // Fetch queue toward the backend
    localparam int ibuf_depth    = 4;
    localparam int ibuf_ptr_bits = 2;

    // First fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // RV32I major opcodes seen by the predecoder
    typedef enum logic [6:0] {
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_other  = 7'b0000000
    } opcode_e;

    // Predecoded control-flow class
    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_cond = 2'd1,
        br_jal  = 2'd2,
        br_jalr = 2'd3
    } br_kind_e;

    // Four-phase req/ack toward the backend
    typedef enum logic [1:0] {
        hs_idle         = 2'd0,
        hs_req          = 2'd1,
        // ack seen, req dropped, waiting for ack low
        hs_wait_release = 2'd2
    } hs_state_e;

endpackage

`default_nettype wire
